// ==== logic/wb_defs.svh ====
`ifndef WB_DEFS_SVH
`define WB_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// line and beat geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// one cache line holds 16 words of 4 bytes
`define WB_LINE_BITS 512

`define WB_WORD_BITS 32

`define WB_BEATS 16

`define WB_IDX_BITS 4

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI encodings
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define WB_AXSIZE_WORD 3'b010  // 4 bytes per beat

`define WB_BURST_INCR 2'b01

`define WB_RESP_OKAY 2'b00

`endif

// ==== logic/wb_pkg.sv ====
`include "wb_defs.svh"

package wb_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // controller states
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [2:0] {
        IDLE,   // waiting for a request
        ADDR,   // awvalid up
        DATA,   // beats in flight
        RESP,   // bready up
        DONE    // waiting for the ack from the cache
    } wb_state_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request address, seen per line or per word
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef union packed {
        struct packed {
            logic [25:0] line_num;
            logic [5:0]  line_off;  // byte within the 64-byte line
        } line;
        struct packed {
            logic [29:0] word_num;  // low 4 bits pick the word in the line
            logic [1:0]  byte_off;
        } word;
    } wb_addr_u;

endpackage

// ==== logic/wb_line_buffer.sv ====
`include "wb_defs.svh"

module wb_line_buffer import wb_pkg::*; (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       line_we,
    input  logic [`WB_LINE_BITS-1:0]   line_data,
    input  logic [`WB_IDX_BITS-1:0]    beat_idx,
    output logic [`WB_WORD_BITS-1:0]   wdata
);

    logic [`WB_LINE_BITS-1:0] line_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // line storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!rstn) begin
            line_q <= '0;
        end else if (line_we) begin
            line_q <= line_data;  // the top blocks this while beats are going out
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // word select
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // word 0 sits in the low bits of the line
    always_comb begin
        wdata = line_q[beat_idx * `WB_WORD_BITS +: `WB_WORD_BITS];
    end

endmodule

// ==== logic/wb_beat_counter.sv ====
`include "wb_defs.svh"

module wb_beat_counter import wb_pkg::*; (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     load,
    input  logic [`WB_IDX_BITS-1:0]  load_idx,
    input  logic                     advance,
    input  logic                     uncache,
    output logic [`WB_IDX_BITS-1:0]  beat_idx,
    output logic                     last_beat
);

    logic single_q;  // set when the transfer is one uncached word

    always_ff @(posedge clk) begin
        if (!rstn) begin
            beat_idx <= '0;
            single_q <= 1'b0;
        end else if (load) begin
            beat_idx <= load_idx;
            single_q <= uncache;
        end else if (advance) begin
            beat_idx <= beat_idx + 1'b1;
        end
    end

    // an uncached word is its own last beat, wherever it sits in the line
    assign last_beat = single_q || (beat_idx == `WB_IDX_BITS'(`WB_BEATS - 1));

endmodule

// ==== logic/wb_addr_gen.sv ====
`include "wb_defs.svh"

module wb_addr_gen import wb_pkg::*; (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     capture,
    input  logic [31:0]              req_addr,
    input  logic                     uncache,
    output logic [31:0]              awaddr,
    output logic [7:0]               awlen,
    output logic [`WB_IDX_BITS-1:0]  first_idx
);

    wb_addr_u addr_q;
    logic     uncache_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            addr_q    <= '0;
            uncache_q <= 1'b0;
        end else if (capture) begin
            addr_q    <= req_addr;
            uncache_q <= uncache;
        end
    end

    always_comb begin
        if (uncache_q) begin
            awaddr    = {addr_q.word.word_num, 2'b00};  // word aligned
            awlen     = 8'd0;
            first_idx = addr_q.word.word_num[`WB_IDX_BITS-1:0];
        end else begin
            awaddr    = {addr_q.line.line_num, 6'b000000};  // line aligned
            awlen     = 8'(`WB_BEATS - 1);
            first_idx = '0;
        end
    end

endmodule

// ==== logic/wb_ctrl_fsm.sv ====
`include "wb_defs.svh"

module wb_ctrl_fsm import wb_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  logic       wr_req,
    input  logic       awready,
    input  logic       wready,
    input  logic       bvalid,
    input  logic [1:0] bresp,
    input  logic       last_beat,
    input  logic       done_ack,
    output logic       awvalid,
    output logic       wvalid,
    output logic       wlast,
    output logic       bready,
    output logic       capture,
    output logic       load,
    output logic       advance,
    output logic       busy,
    output logic       done,
    output logic       err
);

    wb_state_t state;
    wb_state_t state_nxt;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // state register and next state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (wr_req) begin
                    state_nxt = ADDR;
                end
            end
            ADDR: begin
                if (awready) begin
                    state_nxt = DATA;
                end
            end
            DATA: begin
                if (wready && last_beat) begin
                    state_nxt = RESP;
                end
            end
            RESP: begin
                if (bvalid) begin
                    state_nxt = DONE;
                end
            end
            DONE: begin
                if (done_ack) begin
                    state_nxt = IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // handshake and control outputs
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign awvalid = (state == ADDR);
    assign wvalid  = (state == DATA);
    assign bready  = (state == RESP);
    assign done    = (state == DONE);
    assign busy    = (state != IDLE);
    assign wlast   = wvalid && last_beat;

    assign capture = (state == IDLE) && wr_req;  // requests outside IDLE are dropped
    assign load    = awvalid && awready;
    assign advance = wvalid && wready && !last_beat;

    // error flag lives alongside done and clears with the ack
    always_ff @(posedge clk) begin
        if (!rstn) begin
            err <= 1'b0;
        end else if (bready && bvalid) begin
            err <= (bresp != `WB_RESP_OKAY);
        end else if (done && done_ack) begin
            err <= 1'b0;
        end
    end

endmodule

// ==== logic/wb_axi_writer.sv ====
`include "wb_defs.svh"

module wb_axi_writer import wb_pkg::*; (
    input  logic                       clk,
    input  logic                       rstn,
    // cache side
    input  logic                       line_we,
    input  logic [`WB_LINE_BITS-1:0]   line_data,
    input  logic                       wr_req,
    input  logic [31:0]                req_addr,
    input  logic                       uncache,
    input  logic                       done_ack,
    output logic                       busy,
    output logic                       done,
    output logic                       err,
    // AXI write address
    output logic                       awvalid,
    input  logic                       awready,
    output logic [31:0]                awaddr,
    output logic [7:0]                 awlen,
    output logic [2:0]                 awsize,
    output logic [1:0]                 awburst,
    // AXI write data
    output logic                       wvalid,
    input  logic                       wready,
    output logic [`WB_WORD_BITS-1:0]   wdata,
    output logic                       wlast,
    // AXI write response
    output logic                       bready,
    input  logic                       bvalid,
    input  logic [1:0]                 bresp
);

    logic [`WB_IDX_BITS-1:0] beat_idx;
    logic [`WB_IDX_BITS-1:0] first_idx;
    logic                    last_beat;
    logic                    capture;
    logic                    load;
    logic                    advance;
    logic                    buf_we;
    logic                    single_word;

    assign awsize  = `WB_AXSIZE_WORD;
    assign awburst = `WB_BURST_INCR;

    assign buf_we      = line_we && !wvalid;  // hold the line steady while beats go out
    assign single_word = (awlen == 8'd0);     // the registered mode, seen through awlen

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // datapath and control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    wb_line_buffer i_buf (
        .clk       (clk),
        .rstn      (rstn),
        .line_we   (buf_we),
        .line_data (line_data),
        .beat_idx  (beat_idx),
        .wdata     (wdata)
    );

    wb_beat_counter i_cnt (
        .clk       (clk),
        .rstn      (rstn),
        .load      (load),
        .load_idx  (first_idx),
        .advance   (advance),
        .uncache   (single_word),
        .beat_idx  (beat_idx),
        .last_beat (last_beat)
    );

    wb_addr_gen i_addr (
        .clk       (clk),
        .rstn      (rstn),
        .capture   (capture),
        .req_addr  (req_addr),
        .uncache   (uncache),
        .awaddr    (awaddr),
        .awlen     (awlen),
        .first_idx (first_idx)
    );

    wb_ctrl_fsm i_fsm (
        .clk       (clk),
        .rstn      (rstn),
        .wr_req    (wr_req),
        .awready   (awready),
        .wready    (wready),
        .bvalid    (bvalid),
        .bresp     (bresp),
        .last_beat (last_beat),
        .done_ack  (done_ack),
        .awvalid   (awvalid),
        .wvalid    (wvalid),
        .wlast     (wlast),
        .bready    (bready),
        .capture   (capture),
        .load      (load),
        .advance   (advance),
        .busy      (busy),
        .done      (done),
        .err       (err)
    );

endmodule

// ==== verification/wb_clk_gen.sv ====
module wb_clk_gen (
    output logic clk
);

    localparam int HALF_PERIOD = 20;  // 40 units per cycle

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

endmodule

// ==== verification/wb_tb.sv ====
`include "wb_defs.svh"

module wb_tb;

    localparam int          NUM_REC        = 8;
    localparam int          REC_WORDS      = 19;  // uncache, addr, bresp, then 16 line words
    localparam int          TIMEOUT_CYCLES = NUM_REC * 200;
    localparam logic [31:0] SEED           = 32'hb41e_5900;

    logic                       clk;
    logic                       rstn;
    logic                       line_we;
    logic [`WB_LINE_BITS-1:0]   line_data;
    logic                       wr_req;
    logic [31:0]                req_addr;
    logic                       uncache;
    logic                       done_ack;
    logic                       busy;
    logic                       done;
    logic                       err;
    logic                       awvalid;
    logic                       awready;
    logic [31:0]                awaddr;
    logic [7:0]                 awlen;
    logic [2:0]                 awsize;
    logic [1:0]                 awburst;
    logic                       wvalid;
    logic                       wready;
    logic [`WB_WORD_BITS-1:0]   wdata;
    logic                       wlast;
    logic                       bready;
    logic                       bvalid;
    logic [1:0]                 bresp;

    logic [31:0] stim [0:NUM_REC*REC_WORDS-1];

    // the transaction in flight, as the slave and monitor see it
    logic        cur_uncache;
    logic [31:0] cur_addr;
    logic [1:0]  cur_bresp;
    logic [31:0] cur_words [0:`WB_BEATS-1];
    logic [31:0] exp_awaddr;
    logic [7:0]  exp_awlen;
    int          exp_beats;

    int          aw_total;
    int          w_total;
    int          rec_beat;
    logic        b_pending;
    int          cycle_count;

    wb_clk_gen i_clk (
        .clk (clk)
    );

    wb_axi_writer i_dut (
        .clk       (clk),
        .rstn      (rstn),
        .line_we   (line_we),
        .line_data (line_data),
        .wr_req    (wr_req),
        .req_addr  (req_addr),
        .uncache   (uncache),
        .done_ack  (done_ack),
        .busy      (busy),
        .done      (done),
        .err       (err),
        .awvalid   (awvalid),
        .awready   (awready),
        .awaddr    (awaddr),
        .awlen     (awlen),
        .awsize    (awsize),
        .awburst   (awburst),
        .wvalid    (wvalid),
        .wready    (wready),
        .wdata     (wdata),
        .wlast     (wlast),
        .bready    (bready),
        .bvalid    (bvalid),
        .bresp     (bresp)
    );

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t %s: got %h, expected %h", $time, what, actual, expected);
            $display("Regression failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // AXI slave with random stalls
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        void'($urandom(SEED));
        awready   <= 1'b0;
        wready    <= 1'b0;
        bvalid    <= 1'b0;
        bresp     <= 2'b00;
        b_pending <= 1'b0;
        forever begin
            @(posedge clk);
            if (!rstn) begin
                awready   <= 1'b0;
                wready    <= 1'b0;
                bvalid    <= 1'b0;
                b_pending <= 1'b0;
            end else begin
                awready <= ($urandom % 4) != 0;
                wready  <= ($urandom % 4) != 0;
                if (bvalid && bready) begin
                    bvalid <= 1'b0;
                end else if (b_pending && !bvalid && ($urandom % 2) == 0) begin
                    bvalid    <= 1'b1;  // response held until bready
                    bresp     <= cur_bresp;
                    b_pending <= 1'b0;
                end
                if (wvalid && wready && wlast) begin
                    b_pending <= 1'b1;
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // transfer monitor
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(posedge clk) begin
        if (!rstn) begin
            aw_total <= 0;
            w_total  <= 0;
            rec_beat <= 0;
        end else begin
            if (awvalid && awready) begin
                check(awaddr, exp_awaddr, "awaddr");
                check(32'(awlen), 32'(exp_awlen), "awlen");
                check(32'(awsize), 32'd2, "awsize");  // size 2 is four bytes per beat
                check(32'(awburst), 32'd1, "awburst");  // INCR
                aw_total <= aw_total + 1;
                rec_beat <= 0;
            end
            if (wvalid && wready) begin
                if (cur_uncache) begin
                    check(wdata, cur_words[cur_addr[5:2]], "uncached wdata");
                end else begin
                    check(wdata, cur_words[rec_beat[3:0]], "burst wdata");
                end
                check(32'(wlast), 32'(cur_uncache || rec_beat == `WB_BEATS - 1), "wlast");
                w_total  <= w_total + 1;
                rec_beat <= rec_beat + 1;
            end
            if (bready) begin
                check(32'(rec_beat), 32'(exp_beats), "bready before the last beat");
            end
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the transfers did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Regression failed");
        $fatal(1, "timeout");
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic run_record(input int r);
        int                       base;
        int                       aw_start;
        int                       w_start;
        logic [`WB_LINE_BITS-1:0] line_bits;
        base        = r * REC_WORDS;
        cur_uncache = stim[base][0];
        cur_addr    = stim[base + 1];
        cur_bresp   = stim[base + 2][1:0];
        for (int i = 0; i < `WB_BEATS; i++) begin
            cur_words[i]          = stim[base + 3 + i];
            line_bits[i*32 +: 32] = stim[base + 3 + i];  // word 0 in the low bits
        end
        exp_awaddr = cur_uncache ? (cur_addr & 32'hffff_fffc) : (cur_addr & 32'hffff_ffc0);
        exp_awlen  = cur_uncache ? 8'd0 : 8'd15;
        exp_beats  = cur_uncache ? 1 : `WB_BEATS;
        aw_start   = aw_total;
        w_start    = w_total;

        @(posedge clk);
        line_we   <= 1'b1;
        line_data <= line_bits;
        @(posedge clk);
        line_we  <= 1'b0;
        wr_req   <= 1'b1;
        req_addr <= cur_addr;
        uncache  <= cur_uncache;
        @(posedge clk);
        wr_req <= 1'b0;
        @(posedge clk);
        check(32'(busy), 32'd1, "busy after request");
        wr_req   <= 1'b1;  // ignored while the FSM is busy
        req_addr <= ~cur_addr;
        uncache  <= ~cur_uncache;
        @(posedge clk);
        wr_req <= 1'b0;
        while (!done) begin
            @(posedge clk);
        end

        // any response other than OKAY (2'b00) is an error
        check(32'(err), 32'(cur_bresp != 2'b00), "err with done");
        repeat (r % 4) begin
            @(posedge clk);
            check(32'(done), 32'd1, "done held until ack");
            check(32'(err), 32'(cur_bresp != 2'b00), "err held until ack");
        end
        done_ack <= 1'b1;
        @(posedge clk);
        check(32'(done), 32'd1, "done at ack");
        done_ack <= 1'b0;
        @(posedge clk);
        check(32'(busy), 32'd0, "busy after ack");
        check(32'(done), 32'd0, "done after ack");
        check(32'(err), 32'd0, "err after ack");
        check(32'(aw_total - aw_start), 32'd1, "AW transfers per request");
        check(32'(w_total - w_start), 32'(exp_beats), "W beats per request");
    endtask

    initial begin
        rstn      <= 1'b0;
        line_we   <= 1'b0;
        line_data <= '0;
        wr_req    <= 1'b0;
        req_addr  <= '0;
        uncache   <= 1'b0;
        done_ack  <= 1'b0;
        $readmemh("verification/wb_testdata.txt", stim);
        repeat (2) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);
        check(32'(awvalid), 32'd0, "awvalid after reset");
        check(32'(wvalid), 32'd0, "wvalid after reset");
        check(32'(bready), 32'd0, "bready after reset");
        check(32'(done), 32'd0, "done after reset");
        check(32'(err), 32'd0, "err after reset");
        check(32'(busy), 32'd0, "busy after reset");
        for (int r = 0; r < NUM_REC; r++) begin
            run_record(r);
        end
        $display("Regression passed");
        $finish;
    end

endmodule

// ==== verification/wb_testdata.txt ====
// per record: uncache flag, byte address, bresp to return
// then the 16 line words, word 0 first, eight per line
// record 0: cached, aligned
00000000 10000040 00000000
c0a00000 c0a10101 c0a20202 c0a30303 c0a40404 c0a50505 c0a60606 c0a70707
c0a80808 c0a90909 c0aa0a0a c0ab0b0b c0ac0c0c c0ad0d0d c0ae0e0e c0af0f0f

// record 1: uncached, word 5
00000001 20000014 00000000
d1b00000 d1b10101 d1b20202 d1b30303 d1b40404 d1b50505 d1b60606 d1b70707
d1b80808 d1b90909 d1ba0a0a d1bb0b0b d1bc0c0c d1bd0d0d d1be0e0e d1bf0f0f

// record 2: cached, unaligned, slave error
00000000 300001a7 00000002
e2c00000 e2c10101 e2c20202 e2c30303 e2c40404 e2c50505 e2c60606 e2c70707
e2c80808 e2c90909 e2ca0a0a e2cb0b0b e2cc0c0c e2cd0d0d e2ce0e0e e2cf0f0f

// record 3: uncached, word 15 with a byte offset
00000001 4000003e 00000000
f3d00000 f3d10101 f3d20202 f3d30303 f3d40404 f3d50505 f3d60606 f3d70707
f3d80808 f3d90909 f3da0a0a f3db0b0b f3dc0c0c f3dd0d0d f3de0e0e f3df0f0f

// record 4: cached, all offset bits set
00000000 55555fff 00000000
a4e00000 a4e10101 a4e20202 a4e30303 a4e40404 a4e50505 a4e60606 a4e70707
a4e80808 a4e90909 a4ea0a0a a4eb0b0b a4ec0c0c a4ed0d0d a4ee0e0e a4ef0f0f

// record 5: uncached, word 0, decode error
00000001 60000003 00000003
b5f00000 b5f10101 b5f20202 b5f30303 b5f40404 b5f50505 b5f60606 b5f70707
b5f80808 b5f90909 b5fa0a0a b5fb0b0b b5fc0c0c b5fd0d0d b5fe0e0e b5ff0f0f

// record 6: uncached, word 10, exclusive okay
00000001 70000029 00000001
96a00000 96a10101 96a20202 96a30303 96a40404 96a50505 96a60606 96a70707
96a80808 96a90909 96aa0a0a 96ab0b0b 96ac0c0c 96ad0d0d 96ae0e0e 96af0f0f

// record 7: cached, address zero offset
00000000 80000000 00000000
87b00000 87b10101 87b20202 87b30303 87b40404 87b50505 87b60606 87b70707
87b80808 87b90909 87ba0a0a 87bb0b0b 87bc0c0c 87bd0d0d 87be0e0e 87bf0f0f

// ==== files.f ====
+incdir+logic
logic/wb_pkg.sv
logic/wb_line_buffer.sv
logic/wb_beat_counter.sv
logic/wb_addr_gen.sv
logic/wb_ctrl_fsm.sv
logic/wb_axi_writer.sv
verification/wb_clk_gen.sv
verification/wb_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the write-back testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=wb_sim
LOG=sim.log

verilator --binary --timing -f files.f --top-module wb_tb -Mdir "$BUILD_DIR" -o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the log decides the result
if grep -q "^Regression passed$" "$LOG"; then
    echo "simulation result: pass"
    exit 0
else
    echo "simulation result: pass message not found in $LOG"
    exit 1
fi
